//--- Makefile
# Verilator build and run of the execute stage testbench
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= exec_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --binary -j 0
PASS_TEXT ?= sim passed

SOURCES := $(wildcard source/*.sv bench/*.sv)
BIN     := $(BUILD_DIR)/$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)

# the log decides pass or fail, not the exit code of the binary
run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/exec_model_pkg.sv
// ======================================================================
// reference model of the RV32I execute semantics for the testbench
// covers OP, OP-IMM, LUI, AUIPC, JAL, JALR and the six branches
// rd_data is only defined for writing opcodes, redirect_pc on redirect
// ======================================================================
`default_nettype none

package exec_model_pkg;
	import exec_pkg::*;

	// expected outputs of one instruction
	typedef struct packed {
		logic [31:0]     instr;
		logic [4:0]      rd_addr;
		logic            rd_we;
		logic [xlen-1:0] rd_data;
		// rd_data meaningful for this opcode
		logic            data_valid;
		logic            redirect;
		logic [xlen-1:0] redirect_pc;
		logic            illegal;
	} exec_expect_t;

	// integer arithmetic by funct3, alt selects sub and sra
	function automatic logic [xlen-1:0] arith_result(logic [2:0] f3, logic alt,
		logic [xlen-1:0] a, logic [xlen-1:0] b);
		logic [xlen-1:0] r;
		case (f3)
			3'b000:  r = alt ? a - b : a + b;
			3'b001:  r = a << b[4:0];
			3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011:  r = (a < b) ? 32'd1 : 32'd0;
			3'b100:  r = a ^ b;
			// only the low five bits count as shift amount
			// sra kept apart so the shift stays signed
			3'b101: begin
				if (alt)
					r = $signed(a) >>> b[4:0];
				else
					r = a >> b[4:0];
			end
			3'b110:  r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	// branch condition straight from the ISA definition
	function automatic logic branch_taken(logic [2:0] f3, logic [xlen-1:0] a,
		logic [xlen-1:0] b);
		case (f3)
			f3_beq:  return a == b;
			f3_bne:  return a != b;
			f3_blt:  return $signed(a) < $signed(b);
			f3_bge:  return $signed(a) >= $signed(b);
			f3_bltu: return a < b;
			f3_bgeu: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	// expected outputs for one accepted instruction
	function automatic exec_expect_t predict_outputs(logic [31:0] instr,
		logic [xlen-1:0] pc, logic [xlen-1:0] rs1, logic [xlen-1:0] rs2);
		exec_expect_t e;
		logic [xlen-1:0] imm_i;
		logic [xlen-1:0] imm_u;
		logic [xlen-1:0] imm_b;
		logic [xlen-1:0] imm_j;
		logic [2:0] f3;
		imm_i = {{20{instr[31]}}, instr[31:20]};
		imm_u = {instr[31:12], 12'h000};
		imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
		imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
		f3 = instr[14:12];
		e = '0;
		e.instr = instr;
		e.rd_addr = instr[11:7];
		e.data_valid = 1'b1;
		case (instr[6:0])
			opc_op:     e.rd_data = arith_result(f3, instr[30], rs1, rs2);
			// op-imm has no sub, bit 30 only marks srai
			opc_op_imm: e.rd_data = arith_result(f3, (f3 == 3'b101) && instr[30], rs1, imm_i);
			opc_lui:    e.rd_data = imm_u;
			opc_auipc:  e.rd_data = pc + imm_u;
			opc_jal: begin
				e.rd_data = pc + 32'd4;
				e.redirect = 1'b1;
				e.redirect_pc = pc + imm_j;
			end
			opc_jalr: begin
				e.rd_data = pc + 32'd4;
				e.redirect = 1'b1;
				e.redirect_pc = (rs1 + imm_i) & ~32'd1;
			end
			opc_branch: begin
				e.data_valid = 1'b0;
				e.redirect = branch_taken(f3, rs1, rs2);
				e.redirect_pc = pc + imm_b;
			end
			default: begin
				e.data_valid = 1'b0;
				e.illegal = 1'b1;
			end
		endcase
		// x0 is never written
		e.rd_we = e.data_valid && (e.rd_addr != 5'd0);
		return e;
	endfunction

	// short opcode name for error lines
	function automatic string instr_name(logic [31:0] instr);
		case (instr[6:0])
			opc_op:     return "op";
			opc_op_imm: return "op_imm";
			opc_lui:    return "lui";
			opc_auipc:  return "auipc";
			opc_jal:    return "jal";
			opc_jalr:   return "jalr";
			opc_branch: return "branch";
			default:    return "unknown";
		endcase
	endfunction

endpackage

`default_nettype wire

//--- bench/exec_tb.sv
// ======================================================================
// random testbench of the execute stage, fixed seed
// every accepted instruction is checked against the model package
// out_valid must follow in_valid by exactly two clock edges
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module exec_tb import exec_pkg::*, exec_model_pkg::*; ();

	localparam int num_cycles  = 4000;
	localparam int drain_limit = 50;

	logic            clk;
	logic            arst_n;
	logic            in_valid;
	logic [31:0]     instr;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;
	logic            out_valid;
	logic [4:0]      rd_addr;
	logic            rd_we;
	logic [xlen-1:0] rd_data;
	logic            redirect;
	logic [xlen-1:0] redirect_pc;
	logic            illegal;

	integer          seed;
	// expected results in issue order
	exec_expect_t    expq[$];
	// in_valid as seen one and two negedges ago
	logic            hist1 = 1'b0;
	logic            hist2 = 1'b0;
	int              checked = 0;

	exec_unit i_dut (
		.clk         (clk),
		.arst_n      (arst_n),
		.in_valid    (in_valid),
		.instr       (instr),
		.pc          (pc),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.out_valid   (out_valid),
		.rd_addr     (rd_addr),
		.rd_we       (rd_we),
		.rd_data     (rd_data),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.illegal     (illegal)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	// one instruction word from random fields, mostly supported opcodes
	function automatic logic [31:0] random_instr();
		logic [31:0] r;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [2:0]  bf3;
		int          kind;
		r = $random(seed);
		f3 = r[14:12];
		// alternate encoding only where funct3 has one
		f7 = (r[30] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
		kind = {$random(seed)} % 16;
		case ({$random(seed)} % 6)
			0:       bf3 = f3_beq;
			1:       bf3 = f3_bne;
			2:       bf3 = f3_blt;
			3:       bf3 = f3_bge;
			4:       bf3 = f3_bltu;
			default: bf3 = f3_bgeu;
		endcase
		case (kind)
			0, 1, 2, 3: return {f7, r[24:15], f3, r[11:7], opc_op};
			4, 5, 6: begin
				// shifts keep a proper shamt encoding
				if (f3 == 3'b001 || f3 == 3'b101)
					return {f7, r[24:15], f3, r[11:7], opc_op_imm};
				return {r[31:15], f3, r[11:7], opc_op_imm};
			end
			7:          return {r[31:12], r[11:7], opc_lui};
			8:          return {r[31:12], r[11:7], opc_auipc};
			9:          return {r[31:12], r[11:7], opc_jal};
			10:         return {r[31:15], 3'b000, r[11:7], opc_jalr};
			11, 12, 13: return {r[31:15], bf3, r[11:7], opc_branch};
			// destination x0 on purpose
			14:         return {f7, r[24:15], f3, 5'd0, opc_op};
			// low bits other than 11 are outside RV32I
			default:    return {r[31:2], 2'({$random(seed)} % 3)};
		endcase
	endfunction

	// output side, sampled at negedge where everything is settled
	always @(negedge clk) begin
		exec_expect_t e;
		string        name;
		if (arst_n) begin
			check_value("out_valid timing", hist2, out_valid);
			hist2 = hist1;
			hist1 = in_valid;
			if (out_valid && expq.size() == 0) begin
				$display("out_valid high with no instruction pending");
				$display("sim failed");
				$fatal(1);
			end else if (out_valid) begin
				e = expq.pop_front();
				name = instr_name(e.instr);
				check_value({name, " rd_addr"}, e.rd_addr, rd_addr);
				check_value({name, " rd_we"}, e.rd_we, rd_we);
				check_value({name, " redirect"}, e.redirect, redirect);
				check_value({name, " illegal"}, e.illegal, illegal);
				if (e.data_valid)
					check_value({name, " rd_data"}, e.rd_data, rd_data);
				if (e.redirect)
					check_value({name, " redirect_pc"}, e.redirect_pc, redirect_pc);
				checked++;
			end
		end
	end

	// input side
	initial begin
		logic            nv;
		logic [31:0]     ni;
		logic [xlen-1:0] npc;
		logic [xlen-1:0] na;
		logic [xlen-1:0] nb;
		int              waited;
		seed = 91;
		arst_n = 1'b0;
		in_valid = 1'b0;
		instr = '0;
		pc = '0;
		rs1_data = '0;
		rs2_data = '0;
		repeat (10) @(posedge clk);
		// control outputs cleared by reset
		check_value("reset out_valid", 0, out_valid);
		check_value("reset rd_we", 0, rd_we);
		check_value("reset redirect", 0, redirect);
		check_value("reset illegal", 0, illegal);
		arst_n <= 1'b1;
		for (int i = 0; i < num_cycles; i++) begin
			@(posedge clk);
			// roughly three of four cycles carry an instruction
			nv = ({$random(seed)} % 4) != 0;
			ni = random_instr();
			npc = $random(seed) & ~32'h3;
			na = $random(seed);
			// equal operands and opposite signs hit the compare corners
			case ({$random(seed)} % 4)
				0:       nb = na;
				1:       nb = na ^ 32'h8000_0000;
				default: nb = $random(seed);
			endcase
			in_valid <= nv;
			instr <= ni;
			pc <= npc;
			rs1_data <= na;
			rs2_data <= nb;
			if (nv)
				expq.push_back(predict_outputs(ni, npc, na, nb));
		end
		@(posedge clk);
		in_valid <= 1'b0;
		waited = 0;
		while (expq.size() != 0 && waited < drain_limit) begin
			@(posedge clk);
			waited++;
		end
		if (expq.size() != 0) begin
			$display("outputs stopped arriving, %0d instructions still pending", expq.size());
			$display("sim failed");
			$fatal(1);
		end else begin
			$display("%0d instructions checked", checked);
			$display("sim passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- compile.f
source/exec_pkg.sv
source/exec_alu.sv
source/exec_decode.sv
source/exec_resolve.sv
source/exec_unit.sv
bench/exec_model_pkg.sv
bench/exec_tb.sv

//--- source/exec_alu.sv
// ======================================================================
// combinational ALU, zero cycles of latency
// shifts use only the low five bits of src2, as RV32I requires
// slt and sltu return 0 or 1, unknown codes give 0
// no overflow or carry flags leave this block
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module exec_alu import exec_pkg::*; (
	input  alu_op_t                alu_op,
	input  wire logic [xlen-1:0]   src1,
	input  wire logic [xlen-1:0]   src2,
	output logic      [xlen-1:0]   result,
	output logic                   zero
);

	// sum path
	logic [xlen-1:0] sum;

	// difference with one extra bit, top bit is the borrow
	logic [xlen:0]   diff;
	logic            borrow;

	// less-than results derived from the subtraction
	logic            lt_u;
	logic            lt_s;

	// shift amount
	logic [4:0]      shamt;

	// shifter outputs
	logic [xlen-1:0] shl;
	logic [xlen-1:0] shr_l;
	logic [xlen-1:0] shr_a;

	assign sum = src1 + src2;

	// src1 + ~src2 + 1 in xlen+1 bits
	assign diff   = {1'b0, src1} + {1'b0, ~src2} + {{xlen{1'b0}}, 1'b1};
	// carry out low means src1 < src2 unsigned
	assign borrow = ~diff[xlen];
	assign lt_u   = borrow;

	// signed compare
	// operands of different sign, the negative one is smaller
	// same sign, the difference sign bit decides
	assign lt_s = (src1[xlen-1] != src2[xlen-1]) ? src1[xlen-1] : diff[xlen-1];

	assign shamt = src2[4:0];

	assign shl   = src1 << shamt;
	assign shr_l = src1 >> shamt;
	// arithmetic right shift fills with the sign bit
	assign shr_a = $signed(src1) >>> shamt;

	// result select
	always_comb begin
		case (alu_op)
			alu_add: begin
				result = sum;
			end
			alu_sub: begin
				result = diff[xlen-1:0];
			end
			alu_sll: begin
				result = shl;
			end
			alu_slt: begin
				result = {{(xlen-1){1'b0}}, lt_s};
			end
			alu_sltu: begin
				result = {{(xlen-1){1'b0}}, lt_u};
			end
			alu_xor: begin
				result = src1 ^ src2;
			end
			alu_srl: begin
				result = shr_l;
			end
			alu_sra: begin
				result = shr_a;
			end
			alu_or: begin
				result = src1 | src2;
			end
			alu_and: begin
				result = src1 & src2;
			end
			alu_pass_b: begin
				// lui path, immediate straight through
				result = src2;
			end
			default: begin
				// codes 11 to 15 are not used
				result = '0;
			end
		endcase
	end

	// zero flag on the selected result
	// beq and bne look at this after a sub
	assign zero = (result == '0);

endmodule

`default_nettype wire

//--- source/exec_decode.sv
// ======================================================================
// decode register of the execute stage
// accepts one instruction per cycle while in_valid is high, no stall
// unknown opcodes raise dec_illegal and never write the register file
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module exec_decode import exec_pkg::*; (
	input  wire logic              clk,
	input  wire logic              arst_n,
	input  wire logic              in_valid,
	input  wire logic [31:0]       instr,
	input  wire logic [xlen-1:0]   pc,
	input  wire logic [xlen-1:0]   rs1_data,
	input  wire logic [xlen-1:0]   rs2_data,
	output alu_op_t                alu_op,
	output logic      [xlen-1:0]   src1,
	output logic      [xlen-1:0]   src2,
	output logic                   dec_valid,
	output logic      [4:0]        dec_rd,
	output logic                   dec_we,
	output logic                   dec_illegal,
	output logic                   dec_is_branch,
	output logic                   dec_is_jal,
	output logic                   dec_is_jalr,
	output logic      [2:0]        dec_funct3,
	output logic      [xlen-1:0]   dec_pc,
	output logic      [xlen-1:0]   dec_rs1,
	output logic      [xlen-1:0]   dec_imm
);

	// instruction fields
	logic [6:0]      opcode;
	logic [4:0]      rd;
	logic [2:0]      funct3;
	// instr[30] selects sub and sra
	logic            alt;

	// immediates in the standard formats
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_j;

	// opcode class
	logic            is_op;
	logic            is_op_imm;
	logic            is_lui;
	logic            is_auipc;
	logic            is_jal;
	logic            is_jalr;
	logic            is_branch;
	logic            known;

	// next values for the decode registers
	alu_op_t         op_nxt;
	logic [xlen-1:0] imm_nxt;
	logic [xlen-1:0] src1_nxt;
	logic [xlen-1:0] src2_nxt;
	logic            we_nxt;

	assign opcode = instr[6:0];
	assign rd     = instr[11:7];
	assign funct3 = instr[14:12];
	assign alt    = instr[30];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_u = {instr[31:12], 12'b0};
	// branch offset, bit 0 always zero
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	// jump offset, bit 0 always zero
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	assign is_op     = (opcode == opc_op);
	assign is_op_imm = (opcode == opc_op_imm);
	assign is_lui    = (opcode == opc_lui);
	assign is_auipc  = (opcode == opc_auipc);
	assign is_jal    = (opcode == opc_jal);
	assign is_jalr   = (opcode == opc_jalr);
	assign is_branch = (opcode == opc_branch);
	assign known     = is_op | is_op_imm | is_lui | is_auipc | is_jal | is_jalr | is_branch;

	// alu operation and immediate select
	always_comb begin
		op_nxt  = alu_add;
		imm_nxt = '0;
		if (is_op || is_op_imm) begin
			// immediate is only meaningful for op-imm, shamt sits in its low bits
			imm_nxt = imm_i;
			case (funct3)
				// no sub form for op-imm, instr[30] is immediate there
				3'b000:  op_nxt = (is_op && alt) ? alu_sub : alu_add;
				3'b001:  op_nxt = alu_sll;
				3'b010:  op_nxt = alu_slt;
				3'b011:  op_nxt = alu_sltu;
				3'b100:  op_nxt = alu_xor;
				3'b101:  op_nxt = alt ? alu_sra : alu_srl;
				3'b110:  op_nxt = alu_or;
				default: op_nxt = alu_and;
			endcase
		end else if (is_branch) begin
			imm_nxt = imm_b;
			// equality via zero flag, ordering via less-than bit
			case (funct3)
				f3_blt, f3_bge:   op_nxt = alu_slt;
				f3_bltu, f3_bgeu: op_nxt = alu_sltu;
				default:          op_nxt = alu_sub;
			endcase
		end else if (is_lui) begin
			imm_nxt = imm_u;
			op_nxt  = alu_pass_b;
		end else if (is_auipc) begin
			imm_nxt = imm_u;
		end else if (is_jal) begin
			imm_nxt = imm_j;
		end else if (is_jalr) begin
			imm_nxt = imm_i;
		end
	end

	// operand select
	// jumps compute the link address pc + 4 in the alu
	assign src1_nxt = (is_auipc || is_jal || is_jalr) ? pc : rs1_data;
	assign src2_nxt = (is_jal || is_jalr)                   ? xlen'(4) :
	                  (is_op_imm || is_lui || is_auipc)     ? imm_nxt  : rs2_data;

	// no write for branches, unknown opcodes or x0
	assign we_nxt = known && !is_branch && (rd != 5'd0);

	// strobe and control flags
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dec_valid     <= 1'b0;
			dec_we        <= 1'b0;
			dec_illegal   <= 1'b0;
			dec_is_branch <= 1'b0;
			dec_is_jal    <= 1'b0;
			dec_is_jalr   <= 1'b0;
		end else begin
			dec_valid <= in_valid;
			if (in_valid) begin
				dec_we        <= we_nxt;
				dec_illegal   <= !known;
				dec_is_branch <= is_branch;
				dec_is_jal    <= is_jal;
				dec_is_jalr   <= is_jalr;
			end
		end
	end

	// operands and side data, held while no instruction arrives
	always_ff @(posedge clk) begin
		if (in_valid) begin
			alu_op     <= op_nxt;
			src1       <= src1_nxt;
			src2       <= src2_nxt;
			dec_rd     <= rd;
			dec_funct3 <= funct3;
			dec_pc     <= pc;
			dec_rs1    <= rs1_data;
			dec_imm    <= imm_nxt;
		end
	end

endmodule

`default_nettype wire

//--- source/exec_pkg.sv
// ======================================================================
// shared definitions for the RV32I integer execute stage
// xlen is fixed at 32 because the instruction encoding assumes it
// alu operation codes keep the original ALU control encoding
// ======================================================================
`default_nettype none

package exec_pkg;

	// data and address width
	localparam int xlen = 32;

	// alu operation select, 4 bit control code
	typedef enum logic [3:0] {
		alu_add    = 4'd0,
		alu_sub    = 4'd1,
		alu_sll    = 4'd2,
		alu_slt    = 4'd3,
		alu_sltu   = 4'd4,
		alu_xor    = 4'd5,
		alu_srl    = 4'd6,
		alu_sra    = 4'd7,
		alu_or     = 4'd8,
		alu_and    = 4'd9,
		alu_pass_b = 4'd10
	} alu_op_t;

	// major opcodes, instr[6:0]
	// register-register arithmetic
	localparam logic [6:0] opc_op     = 7'b0110011;
	// register-immediate arithmetic
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	// all six conditional branches share this one
	localparam logic [6:0] opc_branch = 7'b1100011;

	// branch condition, funct3 field instr[14:12]
	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	// signed compares
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	// unsigned compares
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	// codes 010 and 011 are reserved in the branch space
	// they decode as never taken

endpackage

`default_nettype wire

//--- source/exec_resolve.sv
// ======================================================================
// resolve register of the execute stage
// branch outcome comes from the ALU result of the decode stage
// outputs hold their last values while out_valid is low
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module exec_resolve import exec_pkg::*; (
	input  wire logic              clk,
	input  wire logic              arst_n,
	input  wire logic              dec_valid,
	input  wire logic [4:0]        dec_rd,
	input  wire logic              dec_we,
	input  wire logic              dec_illegal,
	input  wire logic              dec_is_branch,
	input  wire logic              dec_is_jal,
	input  wire logic              dec_is_jalr,
	input  wire logic [2:0]        dec_funct3,
	input  wire logic [xlen-1:0]   dec_pc,
	input  wire logic [xlen-1:0]   dec_rs1,
	input  wire logic [xlen-1:0]   dec_imm,
	input  wire logic [xlen-1:0]   alu_result,
	input  wire logic              alu_zero,
	output logic                   out_valid,
	output logic      [4:0]        rd_addr,
	output logic                   rd_we,
	output logic      [xlen-1:0]   rd_data,
	output logic                   redirect,
	output logic      [xlen-1:0]   redirect_pc,
	output logic                   illegal
);

	// branch condition met
	logic            taken;
	// control flow change for this instruction
	logic            redir_nxt;
	// target address before and after jalr alignment
	logic [xlen-1:0] base;
	logic [xlen-1:0] target;

	// condition from the flags of sub, slt or sltu
	always_comb begin
		case (dec_funct3)
			f3_beq:           taken = alu_zero;
			f3_bne:           taken = !alu_zero;
			f3_blt, f3_bltu:  taken = alu_result[0];
			f3_bge, f3_bgeu:  taken = !alu_result[0];
			// reserved encodings fall through
			default:          taken = 1'b0;
		endcase
	end

	// jumps always redirect
	assign redir_nxt = dec_is_jal || dec_is_jalr || (dec_is_branch && taken);

	// jalr is register relative, everything else pc relative
	assign base   = dec_is_jalr ? dec_rs1 : dec_pc;
	assign target = (base + dec_imm) & ~{{(xlen-1){1'b0}}, dec_is_jalr};

	// strobe and control outputs
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			rd_we     <= 1'b0;
			redirect  <= 1'b0;
			illegal   <= 1'b0;
		end else begin
			out_valid <= dec_valid;
			if (dec_valid) begin
				rd_we    <= dec_we;
				redirect <= redir_nxt;
				illegal  <= dec_illegal;
			end
		end
	end

	// write data and target
	// link address pc + 4 already comes out of the alu for jumps
	always_ff @(posedge clk) begin
		if (dec_valid) begin
			rd_addr     <= dec_rd;
			rd_data     <= alu_result;
			redirect_pc <= target;
		end
	end

endmodule

`default_nettype wire

//--- source/exec_unit.sv
// ======================================================================
// RV32I integer execute stage, two cycles from in_valid to out_valid
// one instruction per cycle, no stall, no forwarding or flush
// rd_we, redirect and illegal count only while out_valid is high
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module exec_unit import exec_pkg::*; (
	input  wire logic              clk,
	input  wire logic              arst_n,
	input  wire logic              in_valid,
	input  wire logic [31:0]       instr,
	input  wire logic [xlen-1:0]   pc,
	input  wire logic [xlen-1:0]   rs1_data,
	input  wire logic [xlen-1:0]   rs2_data,
	output logic                   out_valid,
	output logic      [4:0]        rd_addr,
	output logic                   rd_we,
	output logic      [xlen-1:0]   rd_data,
	output logic                   redirect,
	output logic      [xlen-1:0]   redirect_pc,
	output logic                   illegal
);

	// decode to alu
	alu_op_t         alu_op;
	logic [xlen-1:0] src1;
	logic [xlen-1:0] src2;

	// decode to resolve
	logic            dec_valid;
	logic [4:0]      dec_rd;
	logic            dec_we;
	logic            dec_illegal;
	logic            dec_is_branch;
	logic            dec_is_jal;
	logic            dec_is_jalr;
	logic [2:0]      dec_funct3;
	logic [xlen-1:0] dec_pc;
	logic [xlen-1:0] dec_rs1;
	logic [xlen-1:0] dec_imm;

	// alu to resolve
	logic [xlen-1:0] alu_result;
	logic            alu_zero;

	// first register stage
	exec_decode u_decode (
		.clk           (clk),
		.arst_n        (arst_n),
		.in_valid      (in_valid),
		.instr         (instr),
		.pc            (pc),
		.rs1_data      (rs1_data),
		.rs2_data      (rs2_data),
		.alu_op        (alu_op),
		.src1          (src1),
		.src2          (src2),
		.dec_valid     (dec_valid),
		.dec_rd        (dec_rd),
		.dec_we        (dec_we),
		.dec_illegal   (dec_illegal),
		.dec_is_branch (dec_is_branch),
		.dec_is_jal    (dec_is_jal),
		.dec_is_jalr   (dec_is_jalr),
		.dec_funct3    (dec_funct3),
		.dec_pc        (dec_pc),
		.dec_rs1       (dec_rs1),
		.dec_imm       (dec_imm)
	);

	// combinational between the two stages
	exec_alu u_alu (
		.alu_op (alu_op),
		.src1   (src1),
		.src2   (src2),
		.result (alu_result),
		.zero   (alu_zero)
	);

	// second register stage
	exec_resolve u_resolve (
		.clk           (clk),
		.arst_n        (arst_n),
		.dec_valid     (dec_valid),
		.dec_rd        (dec_rd),
		.dec_we        (dec_we),
		.dec_illegal   (dec_illegal),
		.dec_is_branch (dec_is_branch),
		.dec_is_jal    (dec_is_jal),
		.dec_is_jalr   (dec_is_jalr),
		.dec_funct3    (dec_funct3),
		.dec_pc        (dec_pc),
		.dec_rs1       (dec_rs1),
		.dec_imm       (dec_imm),
		.alu_result    (alu_result),
		.alu_zero      (alu_zero),
		.out_valid     (out_valid),
		.rd_addr       (rd_addr),
		.rd_we         (rd_we),
		.rd_data       (rd_data),
		.redirect      (redirect),
		.redirect_pc   (redirect_pc),
		.illegal       (illegal)
	);

endmodule

`default_nettype wire
